// ==== rtl/sdcard_defs.svh ====
// ======================================================================
// SD card bus line coding
// Sizes of the CMD frame, the DAT lanes and the CRC16 phase
// ======================================================================

`ifndef SDCARD_DEFS_SVH
`define SDCARD_DEFS_SVH

// Number of DAT lines in 4-bit bus mode
`define SDCARD_DAT_LANES 4

// Start bit, direction, index and argument are all covered by CRC7
`define SDCARD_CMD_PAYLOAD_BITS 40
`define SDCARD_CMD_FRAME_BITS 48

// Width of each lane CRC and length of the CRC phase on DAT
`define SDCARD_CRC16_BITS 16

`endif

// ==== rtl/sdcard_cmd_pkg.sv ====
// ======================================================================
// SD card CMD line types
// Host command fields and the CRC7 value that closes a CMD frame
// ======================================================================

package sdcard_cmd_pkg;

    // One host command as it appears after the start bit
    // Field order follows the bit order on the line, MSB first
    typedef struct packed {
        // Transmission bit, 1 for host to card
        logic        dir;
        // Command index, CMD0 to CMD63
        logic [5:0]  index;
        // Command argument
        logic [31:0] arg;
    } sdcard_cmd_t;

    // CRC7 over the first 40 frame bits
    // Polynomial x^7 + x^3 + 1 with a zero start value
    typedef logic [6:0] sdcard_crc7_t;

endpackage : sdcard_cmd_pkg

// ==== rtl/sdcard_dat_pkg.sv ====
// ======================================================================
// SD card DAT line types
// Nibble on the four DAT lines, lane CRC16 and shared lane strobes
// ======================================================================

`include "sdcard_defs.svh"

package sdcard_dat_pkg;

    // One nibble across the DAT lines
    // Bit k is carried by lane k
    typedef logic [`SDCARD_DAT_LANES-1:0] sdcard_nibble_t;

    // CRC16 of one DAT lane
    // Polynomial x^16 + x^12 + x^5 + 1 with a zero start value
    typedef logic [`SDCARD_CRC16_BITS-1:0] sdcard_crc16_t;

    // Strobes shared by all lane CRC16 generators
    typedef struct packed {
        // Restart the CRC at the first nibble of a block
        logic clear;
        // Take one data bit into the CRC
        logic shift;
    } sdcard_lane_ctrl_t;

endpackage : sdcard_dat_pkg

// ==== rtl/sdcard_crc7.sv ====
// ======================================================================
// CMD line CRC7 generator
// Bit-serial x^7 + x^3 + 1 with a lookahead of the next register value
// ======================================================================

module sdcard_crc7
    import sdcard_cmd_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_nrst,
    input  logic         i_clear,
    input  logic         i_next,
    input  logic         i_dat,
    output sdcard_crc7_t o_crc7
);

    sdcard_crc7_t crc_q;
    sdcard_crc7_t crc_shift;
    logic         fb;

    // Feedback is the outgoing MSB mixed with the new data bit
    assign fb = crc_q[6] ^ i_dat;

    // The feedback bit enters at bit 0 and is folded into bit 3
    assign crc_shift = {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};

    // The lookahead lets the framer take the final CRC
    // in the same cycle as the last payload bit
    assign o_crc7 = crc_shift;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_next) begin
            crc_q <= crc_shift;
        end
    end

endmodule : sdcard_crc7

// ==== rtl/sdcard_crc16.sv ====
// ======================================================================
// DAT lane CRC16 generator
// Bit-serial x^16 + x^12 + x^5 + 1 for one DAT line
// ======================================================================

module sdcard_crc16
    import sdcard_dat_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_nrst,
    input  sdcard_lane_ctrl_t i_ctrl,
    input  logic              i_dat,
    output sdcard_crc16_t     o_crc16
);

    sdcard_crc16_t crc_q;
    sdcard_crc16_t crc_base;
    sdcard_crc16_t crc_shift;
    logic          fb;

    // A clear that comes with a shift restarts from zero
    // so the first bit of a new block is not lost
    assign crc_base = i_ctrl.clear ? '0 : crc_q;

    assign fb = crc_base[15] ^ i_dat;

    // Feedback enters at bit 0 and is folded into bits 5 and 12
    assign crc_shift = {crc_base[14:12], crc_base[11] ^ fb,
                        crc_base[10:5], crc_base[4] ^ fb,
                        crc_base[3:0], fb};

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_ctrl.shift) begin
            crc_q <= crc_shift;
        end else if (i_ctrl.clear) begin
            crc_q <= '0;
        end
    end

    // The collector reads the register once the last bit is in
    assign o_crc16 = crc_q;

endmodule : sdcard_crc16

// ==== rtl/sdcard_cmd_framer.sv ====
// ======================================================================
// CMD line framer
// Sends start bit, command, CRC7 and end bit as one 48-bit frame
// ======================================================================

`include "sdcard_defs.svh"

module sdcard_cmd_framer
    import sdcard_cmd_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_nrst,
    input  logic         i_cmd_start,
    input  sdcard_cmd_t  i_cmd,
    input  sdcard_crc7_t i_crc7,
    output logic         o_crc_clear,
    output logic         o_crc_next,
    output logic         o_crc_dat,
    output logic         o_cmd_line,
    output logic         o_cmd_busy,
    output logic         o_cmd_done
);

    localparam int PAYLOAD = `SDCARD_CMD_PAYLOAD_BITS;
    localparam int FRAME   = `SDCARD_CMD_FRAME_BITS;
    localparam int CNT_W   = $clog2(FRAME);
    // Ones that follow the CRC in the shift register, the first is the end bit
    localparam int FILL    = PAYLOAD - $bits(sdcard_crc7_t);

    logic [PAYLOAD-1:0] shift_q;
    logic [CNT_W-1:0]   bit_cnt_q;
    logic               busy_q;
    logic               done_q;
    logic               start_ok;
    logic               last_payload;
    logic               last_bit;

    // Starts that arrive during a frame are dropped
    assign start_ok = i_cmd_start && !busy_q;

    assign last_payload = busy_q && (bit_cnt_q == CNT_W'(PAYLOAD - 1));
    assign last_bit     = busy_q && (bit_cnt_q == CNT_W'(FRAME - 1));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            shift_q   <= '1;
            bit_cnt_q <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= last_bit;
            if (start_ok) begin
                // Start bit 0 goes out first, ahead of the command fields
                shift_q   <= {1'b0, i_cmd};
                bit_cnt_q <= '0;
                busy_q    <= 1'b1;
            end else if (busy_q) begin
                if (last_payload) begin
                    // Swap in the CRC once the fortieth bit is on the line
                    shift_q <= {i_crc7, {FILL{1'b1}}};
                end else begin
                    shift_q <= {shift_q[PAYLOAD-2:0], 1'b1};
                end
                bit_cnt_q <= last_bit ? '0 : bit_cnt_q + 1'b1;
                busy_q    <= !last_bit;
            end
        end
    end

    // The line follows the shift register MSB and rests high between frames
    assign o_cmd_line = shift_q[PAYLOAD-1];
    assign o_cmd_busy = busy_q;
    assign o_cmd_done = done_q;

    // Each payload bit enters the CRC while it is on the line
    assign o_crc_clear = start_ok;
    assign o_crc_next  = busy_q && (bit_cnt_q < CNT_W'(PAYLOAD));
    assign o_crc_dat   = shift_q[PAYLOAD-1];

    // The host waits for the frame to end before it starts another
    a_no_start_when_busy : assert property (
        @(posedge i_clk) disable iff (!i_nrst) i_cmd_start |-> !busy_q);

    // An accepted start always ends in done after the whole frame
    a_done_after_frame : assert property (
        @(posedge i_clk) disable iff (!i_nrst) start_ok |-> ##(FRAME + 1) done_q);

endmodule : sdcard_cmd_framer

// ==== rtl/sdcard_dat_splitter.sv ====
// ======================================================================
// DAT byte splitter
// Breaks each byte into two nibbles and drives the lane CRC strobes
// ======================================================================

`include "sdcard_defs.svh"

module sdcard_dat_splitter
    import sdcard_dat_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_dat_valid,
    input  logic [7:0]        i_dat_byte,
    input  logic              i_dat_last,
    output logic              o_dat_ready,
    output sdcard_lane_ctrl_t o_lane_ctrl,
    output sdcard_nibble_t    o_nibble,
    output logic              o_nibble_valid,
    output logic              o_block_end
);

    // Block end pulse, 16 CRC nibbles and the end nibble in the collector
    localparam int TAIL   = `SDCARD_CRC16_BITS + 1;
    localparam int TAIL_W = $clog2(TAIL);

    sdcard_nibble_t    low_q;
    logic              low_pend_q;
    logic              last_q;
    logic              first_q;
    logic              tail_q;
    logic [TAIL_W-1:0] tail_cnt_q;
    logic              block_end_q;
    logic              accept;

    // Busy with the low nibble, or waiting out the CRC tail of a block
    assign o_dat_ready = !low_pend_q && !tail_q;
    assign accept      = i_dat_valid && o_dat_ready;

    // High nibble passes straight through, low nibble comes one cycle later
    assign o_nibble       = low_pend_q ? low_q : i_dat_byte[7:4];
    assign o_nibble_valid = accept || low_pend_q;

    always_comb begin
        o_lane_ctrl.shift = o_nibble_valid;
        // Lanes restart on the first nibble of a block
        o_lane_ctrl.clear = accept && first_q;
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            low_q <= i_dat_byte[3:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            low_pend_q  <= 1'b0;
            last_q      <= 1'b0;
            first_q     <= 1'b1;
            tail_q      <= 1'b0;
            tail_cnt_q  <= '0;
            block_end_q <= 1'b0;
        end else begin
            low_pend_q  <= accept;
            // Lane CRCs hold the whole block one cycle after the last low nibble
            block_end_q <= low_pend_q && last_q;
            if (accept) begin
                last_q  <= i_dat_last;
                first_q <= i_dat_last;
            end
            if (low_pend_q && last_q) begin
                tail_q     <= 1'b1;
                tail_cnt_q <= '0;
            end else if (tail_q) begin
                tail_q     <= (tail_cnt_q != TAIL_W'(TAIL - 1));
                tail_cnt_q <= tail_cnt_q + 1'b1;
            end
        end
    end

    assign o_block_end = block_end_q;

    // Bytes only come when the splitter is ready for them
    a_no_byte_when_busy : assert property (
        @(posedge i_clk) disable iff (!i_nrst) i_dat_valid |-> o_dat_ready);

endmodule : sdcard_dat_splitter

// ==== rtl/sdcard_dat_collector.sv ====
// ======================================================================
// DAT line collector
// Puts data nibbles, then all lane CRC16s, then the end nibble on DAT
// ======================================================================

`include "sdcard_defs.svh"

module sdcard_dat_collector
    import sdcard_dat_pkg::*;
(
    input  logic                                   i_clk,
    input  logic                                   i_nrst,
    input  logic                                   i_nibble_valid,
    input  sdcard_nibble_t                         i_nibble,
    input  logic                                   i_block_end,
    input  sdcard_crc16_t [`SDCARD_DAT_LANES-1:0]  i_lane_crc,
    output sdcard_nibble_t                         o_dat_lines,
    output logic                                   o_dat_busy,
    output logic                                   o_dat_done
);

    localparam int LANES = `SDCARD_DAT_LANES;
    localparam int CRC_W = `SDCARD_CRC16_BITS;
    localparam int CNT_W = $clog2(CRC_W);

    sdcard_crc16_t [LANES-1:0] crc_sr_q;
    sdcard_nibble_t            lines_q;
    sdcard_nibble_t            load_msb;
    sdcard_nibble_t            sr_msb;
    logic [CNT_W-1:0]          crc_cnt_q;
    logic                      crc_phase_q;
    logic                      crc_last;
    logic                      busy_q;
    logic                      done_q;

    // Gather the MSB of every lane into one nibble
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            load_msb[k] = i_lane_crc[k][CRC_W-1];
            sr_msb[k]   = crc_sr_q[k][CRC_W-1];
        end
    end

    assign crc_last = crc_phase_q && (crc_cnt_q == CNT_W'(CRC_W - 1));

    // The MSB goes straight to the lines at load, the rest waits in the shifters
    always_ff @(posedge i_clk) begin
        for (int k = 0; k < LANES; k++) begin
            if (i_block_end) begin
                crc_sr_q[k] <= i_lane_crc[k] << 1;
            end else if (crc_phase_q) begin
                crc_sr_q[k] <= crc_sr_q[k] << 1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            lines_q     <= '1;
            crc_cnt_q   <= '0;
            crc_phase_q <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= crc_last;
            if (i_nibble_valid) begin
                lines_q <= i_nibble;
            end else if (i_block_end) begin
                lines_q     <= load_msb;
                crc_cnt_q   <= '0;
                crc_phase_q <= 1'b1;
            end else if (crc_phase_q) begin
                // After the sixteenth CRC nibble every lane sends its end bit
                lines_q     <= crc_last ? '1 : sr_msb;
                crc_cnt_q   <= crc_cnt_q + 1'b1;
                crc_phase_q <= !crc_last;
            end else begin
                lines_q <= '1;
            end
            // Busy covers the block from its first nibble through the end nibble
            if (i_nibble_valid || i_block_end) begin
                busy_q <= 1'b1;
            end else if (done_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign o_dat_lines = lines_q;
    assign o_dat_busy  = busy_q;
    assign o_dat_done  = done_q;

    // The splitter holds off new bytes for the whole CRC tail
    a_no_nibble_in_crc : assert property (
        @(posedge i_clk) disable iff (!i_nrst) i_nibble_valid |-> !crc_phase_q);

endmodule : sdcard_dat_collector

// ==== rtl/sdcard_bus_crc_top.sv ====
// ======================================================================
// SD card bus line coding top level
// CMD framer with CRC7, DAT splitter, lane CRC16s and DAT collector
// ======================================================================

`include "sdcard_defs.svh"

module sdcard_bus_crc_top
    import sdcard_cmd_pkg::*;
    import sdcard_dat_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_nrst,
    input  logic           i_cmd_start,
    input  sdcard_cmd_t    i_cmd,
    input  logic           i_dat_valid,
    input  logic [7:0]     i_dat_byte,
    input  logic           i_dat_last,
    output logic           o_cmd_line,
    output logic           o_cmd_busy,
    output logic           o_cmd_done,
    output logic           o_dat_ready,
    output sdcard_nibble_t o_dat_lines,
    output logic           o_dat_busy,
    output logic           o_dat_done
);

    logic                                  crc_clear;
    logic                                  crc_next;
    logic                                  crc_dat;
    sdcard_crc7_t                          crc7;
    sdcard_lane_ctrl_t                     lane_ctrl;
    sdcard_nibble_t                        nibble;
    logic                                  nibble_valid;
    logic                                  block_end;
    sdcard_crc16_t [`SDCARD_DAT_LANES-1:0] lane_crc;

    // CMD path
    sdcard_cmd_framer u_cmd_framer (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_cmd_start (i_cmd_start),
        .i_cmd       (i_cmd),
        .i_crc7      (crc7),
        .o_crc_clear (crc_clear),
        .o_crc_next  (crc_next),
        .o_crc_dat   (crc_dat),
        .o_cmd_line  (o_cmd_line),
        .o_cmd_busy  (o_cmd_busy),
        .o_cmd_done  (o_cmd_done)
    );

    sdcard_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (crc_dat),
        .o_crc7  (crc7)
    );

    // DAT path
    sdcard_dat_splitter u_dat_splitter (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_dat_valid    (i_dat_valid),
        .i_dat_byte     (i_dat_byte),
        .i_dat_last     (i_dat_last),
        .o_dat_ready    (o_dat_ready),
        .o_lane_ctrl    (lane_ctrl),
        .o_nibble       (nibble),
        .o_nibble_valid (nibble_valid),
        .o_block_end    (block_end)
    );

    // Every lane shares the strobes and takes its own bit of the nibble
    for (genvar k = 0; k < `SDCARD_DAT_LANES; k++) begin : g_lane
        sdcard_crc16 u_crc16 (
            .i_clk   (i_clk),
            .i_nrst  (i_nrst),
            .i_ctrl  (lane_ctrl),
            .i_dat   (nibble[k]),
            .o_crc16 (lane_crc[k])
        );
    end

    sdcard_dat_collector u_dat_collector (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_nibble_valid (nibble_valid),
        .i_nibble       (nibble),
        .i_block_end    (block_end),
        .i_lane_crc     (lane_crc),
        .o_dat_lines    (o_dat_lines),
        .o_dat_busy     (o_dat_busy),
        .o_dat_done     (o_dat_done)
    );

endmodule : sdcard_bus_crc_top

// ==== testbench/tb_sdcard_bus_crc.sv ====
// ======================================================================
// SD card bus line coding testbench
// Reads command and block cases, runs the CMD and DAT paths together,
// captures both bus outputs and checks frames, nibbles and CRCs
// ======================================================================

`include "sdcard_defs.svh"

module tb_sdcard_bus_crc
    import sdcard_cmd_pkg::*;
    import sdcard_dat_pkg::*;
();

    localparam int    LANES      = `SDCARD_DAT_LANES;
    localparam int    CRC_W      = `SDCARD_CRC16_BITS;
    localparam int    PAYLOAD    = `SDCARD_CMD_PAYLOAD_BITS;
    localparam int    FRAME      = `SDCARD_CMD_FRAME_BITS;
    localparam int    SEED       = 58321;
    localparam int    WAIT_LIMIT = 200;
    localparam string CASE_FILE  = "testbench/sdcard_crc_cases.txt";

    logic           i_clk;
    logic           i_nrst;
    logic           i_cmd_start;
    sdcard_cmd_t    i_cmd;
    logic           i_dat_valid;
    logic [7:0]     i_dat_byte;
    logic           i_dat_last;
    logic           o_cmd_line;
    logic           o_cmd_busy;
    logic           o_cmd_done;
    logic           o_dat_ready;
    sdcard_nibble_t o_dat_lines;
    logic           o_dat_busy;
    logic           o_dat_done;

    // Case storage, blocks keep their bytes in one flat queue
    sdcard_cmd_t   cmd_list[$];
    sdcard_crc7_t  cmd_crc[$];
    logic [7:0]    blk_bytes[$];
    int            blk_first[$];
    int            blk_len[$];
    sdcard_crc16_t blk_crc[$];

    int          checks;
    int          errors;
    int          timeouts;
    int unsigned seed_val;

    sdcard_bus_crc_top UUT (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_cmd_start (i_cmd_start),
        .i_cmd       (i_cmd),
        .i_dat_valid (i_dat_valid),
        .i_dat_byte  (i_dat_byte),
        .i_dat_last  (i_dat_last),
        .o_cmd_line  (o_cmd_line),
        .o_cmd_busy  (o_cmd_busy),
        .o_cmd_done  (o_cmd_done),
        .o_dat_ready (o_dat_ready),
        .o_dat_lines (o_dat_lines),
        .o_dat_busy  (o_dat_busy),
        .o_dat_done  (o_dat_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_nibble(input string name, input sdcard_nibble_t exp,
                                input sdcard_nibble_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic check_crc7(input string name, input sdcard_crc7_t exp,
                              input sdcard_crc7_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic check_crc16(input string name, input sdcard_crc16_t exp,
                               input sdcard_crc16_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    // Records are a keyword, then fields in hex; a lone # starts a comment line
    task automatic read_cases();
        int           fd;
        int           rc;
        int           n;
        bit           more;
        logic [63:0]  kind;
        logic [1023:0] rest;
        logic [31:0]  v_dir;
        logic [31:0]  v_idx;
        logic [31:0]  v_arg;
        logic [31:0]  v_val;
        sdcard_cmd_t  cmd;
        fd = $fopen(CASE_FILE, "r");
        more = (fd != 0);
        if (fd == 0) begin
            $display("Cannot open the case file %s", CASE_FILE);
            errors++;
        end
        while (more) begin
            rc = $fscanf(fd, "%s", kind);
            if (rc != 1) begin
                more = 0;
            end else if (kind == "#") begin
                rc = $fgets(rest, fd);
            end else if (kind == "cmd") begin
                rc = $fscanf(fd, "%h %h %h %h", v_dir, v_idx, v_arg, v_val);
                cmd.dir   = v_dir[0];
                cmd.index = v_idx[5:0];
                cmd.arg   = v_arg;
                cmd_list.push_back(cmd);
                cmd_crc.push_back(v_val[6:0]);
            end else if (kind == "dat") begin
                rc = $fscanf(fd, "%d", n);
                blk_first.push_back(blk_bytes.size());
                blk_len.push_back(n);
                for (int i = 0; i < n; i++) begin
                    rc = $fscanf(fd, "%h", v_val);
                    blk_bytes.push_back(v_val[7:0]);
                end
                // Expected CRCs come lane 0 first
                for (int k = 0; k < LANES; k++) begin
                    rc = $fscanf(fd, "%h", v_val);
                    blk_crc.push_back(v_val[CRC_W-1:0]);
                end
            end else begin
                $display("Unknown record kind in the case file");
                errors++;
                more = 0;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (cmd_list.size() == 0 || blk_len.size() == 0) begin
            $display("The case file holds no command or no data block");
            errors++;
        end
    endtask

    // Sends one command and follows its 48 bits from the cycle after the strobe
    task automatic send_cmd(input int c);
        logic [PAYLOAD-1:0] exp_payload;
        sdcard_crc7_t       crc_cap;
        int                 waited;
        string              tag;
        tag = $sformatf("cmd%0d", c);
        // The covered part is the start bit followed by the command fields
        exp_payload = {1'b0, cmd_list[c]};
        crc_cap = '0;
        waited = 0;
        while (o_cmd_busy && waited < WAIT_LIMIT) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_cmd_busy) begin
            $display("Timeout while %s waited for the CMD path to go idle", tag);
            timeouts++;
        end
        @(posedge i_clk);
        i_cmd_start <= 1'b1;
        i_cmd       <= cmd_list[c];
        @(posedge i_clk);
        i_cmd_start <= 1'b0;
        for (int n = 0; n < FRAME; n++) begin
            @(negedge i_clk);
            check_bit({tag, " busy"}, 1'b1, o_cmd_busy);
            check_bit({tag, " early done"}, 1'b0, o_cmd_done);
            if (n < PAYLOAD) begin
                check_bit($sformatf("%s frame bit %0d", tag, n),
                          exp_payload[PAYLOAD-1-n], o_cmd_line);
            end else if (n < FRAME - 1) begin
                // CRC7 arrives MSB first
                crc_cap = {crc_cap[5:0], o_cmd_line};
            end else begin
                check_bit({tag, " end bit"}, 1'b1, o_cmd_line);
            end
        end
        check_crc7({tag, " crc7"}, cmd_crc[c], crc_cap);
        @(negedge i_clk);
        check_bit({tag, " busy after frame"}, 1'b0, o_cmd_busy);
        check_bit({tag, " done"}, 1'b1, o_cmd_done);
    endtask

    task automatic strobe_byte(input logic [7:0] value, input logic last);
        i_dat_valid <= 1'b1;
        i_dat_byte  <= value;
        i_dat_last  <= last;
    endtask

    // Sends one block, checks its nibbles, then rebuilds every lane CRC
    task automatic send_block(input int b);
        sdcard_crc16_t  crc_cap [LANES];
        sdcard_nibble_t lines;
        logic [7:0]     data;
        int             first;
        int             len;
        int             waited;
        string          tag;
        tag = $sformatf("blk%0d", b);
        first = blk_first[b];
        len = blk_len[b];
        for (int k = 0; k < LANES; k++) begin
            crc_cap[k] = '0;
        end
        waited = 0;
        while (!o_dat_ready && waited < WAIT_LIMIT) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_dat_ready) begin
            $display("Timeout while %s waited for the DAT path to be ready", tag);
            timeouts++;
        end
        @(posedge i_clk);
        strobe_byte(blk_bytes[first], len == 1);
        for (int i = 0; i < len; i++) begin
            data = blk_bytes[first + i];
            @(posedge i_clk);
            i_dat_valid <= 1'b0;
            i_dat_last  <= 1'b0;
            @(negedge i_clk);
            check_nibble($sformatf("%s byte%0d high nibble", tag, i), data[7:4], o_dat_lines);
            check_bit($sformatf("%s byte%0d ready low", tag, i), 1'b0, o_dat_ready);
            // The next byte goes out while the low nibble is on the lines
            @(posedge i_clk);
            if (i + 1 < len) begin
                strobe_byte(blk_bytes[first + i + 1], i + 2 == len);
            end
            @(negedge i_clk);
            check_nibble($sformatf("%s byte%0d low nibble", tag, i), data[3:0], o_dat_lines);
            // Ready comes back for the next byte but stays low after the last one
            check_bit($sformatf("%s byte%0d ready on low nibble", tag, i), i + 1 < len,
                      o_dat_ready);
        end
        // Nibble j holds bit 15-j of each lane CRC
        for (int j = 0; j < CRC_W; j++) begin
            @(negedge i_clk);
            lines = o_dat_lines;
            for (int k = 0; k < LANES; k++) begin
                crc_cap[k][CRC_W-1-j] = lines[k];
            end
            check_bit({tag, " busy in crc"}, 1'b1, o_dat_busy);
            check_bit({tag, " early done"}, 1'b0, o_dat_done);
            check_bit({tag, " ready in crc"}, 1'b0, o_dat_ready);
        end
        @(negedge i_clk);
        check_nibble({tag, " end nibble"}, '1, o_dat_lines);
        check_bit({tag, " done"}, 1'b1, o_dat_done);
        check_bit({tag, " busy on end nibble"}, 1'b1, o_dat_busy);
        check_bit({tag, " ready on end nibble"}, 1'b1, o_dat_ready);
        for (int k = 0; k < LANES; k++) begin
            check_crc16($sformatf("%s lane%0d crc16", tag, k), blk_crc[b * LANES + k],
                        crc_cap[k]);
        end
    endtask

    task automatic run_cmds();
        int gap;
        for (int c = 0; c < cmd_list.size(); c++) begin
            gap = $urandom % 4;
            repeat (gap) @(negedge i_clk);
            send_cmd(c);
        end
    endtask

    // Odd blocks start right after the previous done to cross a block boundary
    task automatic run_blocks();
        int gap;
        for (int b = 0; b < blk_len.size(); b++) begin
            gap = (b % 2 == 1) ? 0 : $urandom % 4;
            repeat (gap) @(negedge i_clk);
            send_block(b);
        end
    endtask

    initial begin
        checks = 0;
        errors = 0;
        timeouts = 0;
        seed_val = $urandom(SEED);
        i_nrst = 1'b0;
        i_cmd_start = 1'b0;
        i_cmd = '0;
        i_dat_valid = 1'b0;
        i_dat_byte = '0;
        i_dat_last = 1'b0;
        read_cases();
        repeat (8) @(posedge i_clk);
        i_nrst <= 1'b1;
        // Idle state right after reset
        @(negedge i_clk);
        check_bit("idle cmd line", 1'b1, o_cmd_line);
        check_bit("idle cmd busy", 1'b0, o_cmd_busy);
        check_bit("idle cmd done", 1'b0, o_cmd_done);
        check_nibble("idle dat lines", '1, o_dat_lines);
        check_bit("idle dat busy", 1'b0, o_dat_busy);
        check_bit("idle dat done", 1'b0, o_dat_done);
        check_bit("idle dat ready", 1'b1, o_dat_ready);
        // Both paths run side by side
        fork
            run_cmds();
            run_blocks();
        join
        $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_sdcard_bus_crc

// ==== testbench/sdcard_crc_cases.txt ====
# cmd <dir> <index hex> <argument hex> <expected crc7 hex>
# dat <byte count> <bytes hex ...> <expected crc16 hex for lane 0 1 2 3>
# CMD0 GO_IDLE_STATE
cmd 1 00 00000000 4A
# CMD17 READ_SINGLE_BLOCK at address 0
cmd 1 11 00000000 2A
# CMD8 SEND_IF_COND with check pattern
cmd 1 08 000001AA 43
# CMD55 APP_CMD
cmd 1 37 00000000 32
# ACMD41 with the high capacity bit
cmd 1 29 40000000 3B
# CMD58 READ_OCR
cmd 1 3A 00000000 7E
# Short blocks leave the lanes with only a few bits each
dat 1 A5 1021 2042 1021 2042
dat 4 12 34 56 78 14A0 0C60 F3FF 1021
dat 3 0F F0 81 8318 9339 9339 B37B
dat 2 FF 00 C18C C18C C18C C18C
# Sixteen bits per lane run the feedback over a full register
dat 8 FF FF FF FF FF FF FF FF 1D0F 1D0F 1D0F 1D0F
dat 8 12 34 56 78 FF FF FF FF EC45 BF7C 3E8C 2DC1

// ==== sources.f ====
+incdir+rtl
rtl/sdcard_cmd_pkg.sv
rtl/sdcard_dat_pkg.sv
rtl/sdcard_crc7.sv
rtl/sdcard_crc16.sv
rtl/sdcard_cmd_framer.sv
rtl/sdcard_dat_splitter.sv
rtl/sdcard_dat_collector.sv
rtl/sdcard_bus_crc_top.sv
testbench/tb_sdcard_bus_crc.sv

// ==== Bender.yml ====
package:
  name: sdcard_bus_crc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sdcard_cmd_pkg.sv
      - rtl/sdcard_dat_pkg.sv
      - rtl/sdcard_crc7.sv
      - rtl/sdcard_crc16.sv
      - rtl/sdcard_cmd_framer.sv
      - rtl/sdcard_dat_splitter.sv
      - rtl/sdcard_dat_collector.sv
      - rtl/sdcard_bus_crc_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_sdcard_bus_crc.sv
